// File: include/cpu_tests.svh
// Program loading helpers, BCD helpers and directed CPU tests
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = data_t'(i[15:8] ^ {i[6:0], i[7]} ^ 8'ha5);  // Depends on whole address
        end
    endtask

    task automatic start_program();
        fill_memory();
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_what.delete();
        load_ptr    = PROG_BASE;
        data_ptr    = DATA_BASE;
        next_result = RESULT_BASE;
        mem[RESET_VECTOR]         = PROG_BASE[7:0];
        mem[RESET_VECTOR + 16'd1] = PROG_BASE[15:8];
    endtask

    task automatic emit(data_t b);
        mem[load_ptr] = b;
        load_ptr      = load_ptr + 16'd1;
    endtask

    task automatic imm_op(data_t opc, data_t value);
        emit(opc);
        emit(value);
    endtask

    task automatic abs_op(data_t opc, addr_t target);
        emit(opc);
        emit(target[7:0]);                         // Little endian operand
        emit(target[15:8]);
    endtask

    // Store to the next result slot and record the write it must make
    task automatic expect_store(data_t opc, data_t value, string what);
        abs_op(opc, next_result);
        exp_addr.push_back(next_result);
        exp_data.push_back(value);
        exp_what.push_back(what);
        next_result = next_result + 16'd1;
    endtask

    // C shows up as A = 0 + 0 + C
    task automatic expect_carry(logic c, string what);
        imm_op(OPC_LDA_IMM, 8'h00);
        imm_op(OPC_ADC_IMM, 8'h00);
        expect_store(OPC_STA_ABS, {7'b0, c}, what);
    endtask

    task automatic expect_regs(data_t a, data_t x, data_t y, string what);
        expect_store(OPC_STA_ABS, a, {what, " A"});
        expect_store(OPC_STX_ABS, x, {what, " X"});
        expect_store(OPC_STY_ABS, y, {what, " Y"});
    endtask

    // Set C, load A, then apply opc to b in immediate or absolute form
    task automatic apply_operation(data_t opc, data_t a, data_t b, logic cin, logic absolute);
        emit(cin ? OPC_SEC : OPC_CLC);
        imm_op(OPC_LDA_IMM, a);
        if (absolute) begin
            mem[data_ptr] = b;
            abs_op(opc | 8'h04, data_ptr);         // Absolute column, same row
            data_ptr = data_ptr + 16'd1;
        end else begin
            imm_op(opc, b);
        end
    endtask

    task automatic run_program();
        halt_addr = load_ptr;
        abs_op(OPC_JMP_ABS, halt_addr);            // Jump to itself
        pulse_reset();
        check_results();
    endtask

    function automatic int bcd_value(data_t v);
        return v[7:4] * 10 + v[3:0];
    endfunction

    function automatic data_t to_bcd(int n);
        return data_t'((n / 10) * 16 + n % 10);
    endfunction

    task automatic reset_and_jump();
        start_program();
        imm_op(OPC_LDA_IMM, 8'h5a);
        abs_op(OPC_JMP_ABS, load_ptr + 16'd6);     // Past itself and the next store
        abs_op(OPC_STA_ABS, RESULT_BASE + 16'h00f0);  // Skipped
        expect_store(OPC_STA_ABS, 8'h5a, "store at JMP target");
        halt_addr = load_ptr;
        abs_op(OPC_JMP_ABS, halt_addr);
        pulse_reset();
        assert (addr == RESET_VECTOR)
            else report_mismatch("vector low byte not read first after reset");
        @(negedge clk);
        assert (addr == RESET_VECTOR + 16'd1)
            else report_mismatch("vector high byte not read in second cycle");
        @(negedge clk);
        assert (addr == PROG_BASE && rdata == OPC_LDA_IMM)
            else report_mismatch("first opcode not fetched from vector address");
        check_results();
    endtask

    task automatic loads_and_transfers();
        data_t a, x, y;
        start_program();
        a = data_t'($random(seed));
        x = data_t'($random(seed));
        y = data_t'($random(seed));
        imm_op(OPC_LDA_IMM, a);
        imm_op(OPC_LDX_IMM, x);
        imm_op(OPC_LDY_IMM, y);
        expect_regs(a, x, y, "immediate load");
        a = data_t'($random(seed));
        x = data_t'($random(seed));
        y = data_t'($random(seed));
        mem[DATA_BASE]         = a;
        mem[DATA_BASE + 16'd1] = x;
        mem[DATA_BASE + 16'd2] = y;
        abs_op(OPC_LDA_ABS, DATA_BASE);
        abs_op(OPC_LDX_ABS, DATA_BASE + 16'd1);
        abs_op(OPC_LDY_ABS, DATA_BASE + 16'd2);
        expect_regs(a, x, y, "absolute load");
        emit(OPC_TAX);
        x = a;
        emit(OPC_TYA);
        a = y;
        emit(OPC_INX);
        x = x + 8'd1;
        emit(OPC_DEY);
        y = y - 8'd1;
        expect_regs(a, x, y, "TAX TYA INX DEY");
        emit(OPC_TAY);
        y = a;
        emit(OPC_TXA);
        a = x;
        emit(OPC_INY);
        y = y + 8'd1;
        emit(OPC_DEX);
        x = x - 8'd1;
        expect_regs(a, x, y, "TAY TXA INY DEX");
        imm_op(OPC_LDX_IMM, 8'hff);
        emit(OPC_INX);                             // Wraps to 00
        imm_op(OPC_LDY_IMM, 8'h00);
        emit(OPC_DEY);                             // Wraps to FF
        emit(OPC_NOP);
        emit(8'h02);                               // Unknown opcode
        expect_regs(a, 8'h00, 8'hff, "wraparound and NOP");
        run_program();
    endtask

    task automatic logic_and_add_sub();
        data_t      a, b;
        logic       cin;
        logic [8:0] sum;
        int         diff;
        start_program();
        for (int i = 0; i < 6; i++) begin
            a   = data_t'($random(seed));
            b   = data_t'($random(seed));
            cin = i[1];
            apply_operation(OPC_ORA_IMM, a, b, cin, i[0]);
            expect_store(OPC_STA_ABS, a | b, "ORA");
            apply_operation(OPC_AND_IMM, a, b, cin, i[0]);
            expect_store(OPC_STA_ABS, a & b, "AND");
            apply_operation(OPC_EOR_IMM, a, b, cin, i[0]);
            expect_store(OPC_STA_ABS, a ^ b, "EOR");
            apply_operation(OPC_ADC_IMM, a, b, cin, i[0]);
            sum = a + b + cin;
            expect_store(OPC_STA_ABS, sum[7:0], "ADC result");
            expect_carry(sum[8], "ADC carry");
            apply_operation(OPC_SBC_IMM, a, b, cin, i[0]);
            diff = int'(a) - int'(b) - (cin ? 0 : 1);   // Clear C borrows one
            expect_store(OPC_STA_ABS, data_t'(diff), "SBC result");
            expect_carry(diff >= 0, "SBC carry");
        end
        run_program();
    endtask

    task automatic compare_carry();
        data_t a, b;
        logic  ge;
        start_program();
        for (int i = 0; i < 6; i++) begin
            a = data_t'($random(seed));
            case (i)
                0:       b = a;                    // Equal
                1:       b = a + 8'd1;
                2:       b = a - 8'd1;
                default: b = data_t'($random(seed));
            endcase
            ge = (a >= b);
            apply_operation(OPC_CMP_IMM, a, b, !ge, i[0]);  // C starts opposite
            expect_store(OPC_STA_ABS, a, "A after CMP");
            expect_carry(ge, "CMP carry");
        end
        run_program();
    endtask

    task automatic decimal_mode();
        data_t a, b;
        logic  cin;
        int    n;
        start_program();
        emit(OPC_SED);
        for (int i = 0; i < 6; i++) begin
            a   = to_bcd($unsigned($random(seed)) % 100);
            b   = to_bcd($unsigned($random(seed)) % 100);
            cin = i[1];
            apply_operation(OPC_ADC_IMM, a, b, cin, i[0]);
            n = bcd_value(a) + bcd_value(b) + cin;
            expect_store(OPC_STA_ABS, to_bcd(n % 100), "decimal ADC result");
            expect_carry(n >= 100, "decimal ADC carry");
            apply_operation(OPC_SBC_IMM, a, b, cin, i[0]);
            n = bcd_value(a) - bcd_value(b) - (cin ? 0 : 1);
            expect_store(OPC_STA_ABS, to_bcd((n + 100) % 100), "decimal SBC result");
            expect_carry(n >= 0, "decimal SBC carry");
        end
        emit(OPC_CLD);
        apply_operation(OPC_ADC_IMM, 8'h19, 8'h28, 1'b0, 1'b0);
        expect_store(OPC_STA_ABS, 8'h41, "binary ADC after CLD");  // BCD would give 47
        apply_operation(OPC_SBC_IMM, 8'h10, 8'h01, 1'b1, 1'b0);
        expect_store(OPC_STA_ABS, 8'h0f, "binary SBC after CLD");  // BCD would give 09
        run_program();
    endtask

`endif

// File: dv/cpu_tb.sv
// CPU testbench top with clock, reset, memory model, write log, DUT and test sequence
`timescale 1ns/100ps

module cpu_tb
    import isa_pkg::*;
();

    localparam addr_t PROG_BASE   = 16'h0200;      // Reset vector target
    localparam addr_t RESULT_BASE = 16'h0500;      // Store targets
    localparam addr_t DATA_BASE   = 16'h0400;      // Absolute operands
    localparam int    WAIT_LIMIT  = 4000;          // Cycles per wait loop

    logic  clk;
    logic  reset;
    addr_t addr;
    data_t rdata;
    data_t wdata;
    logic  we;

    data_t  mem [0:65535];                         // 64 KB byte memory
    addr_t  log_addr[$];                           // Writes seen on the bus
    data_t  log_data[$];
    addr_t  exp_addr[$];                           // Writes the program must make
    data_t  exp_data[$];
    string  exp_what[$];
    addr_t  load_ptr;                              // Next program byte
    addr_t  data_ptr;                              // Next absolute operand
    addr_t  next_result;                           // Next store target
    addr_t  halt_addr;                             // Final JMP to itself
    integer seed;

    cpu_top u_cpu_top (
        .clk   (clk),
        .reset (reset),
        .addr  (addr),
        .rdata (rdata),
        .wdata (wdata),
        .we    (we)
    );

    assign rdata = mem[addr];                      // Async read in the same cycle as addr

    always @(posedge clk) begin
        if (we === 1'b1) begin
            mem[addr] <= wdata;
            log_addr.push_back(addr);
            log_data.push_back(wdata);
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                    // 100 ns period
    end

    task automatic stop_with_error(string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(string msg);
        stop_with_error($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    // Entered and left on a falling edge
    task automatic pulse_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // Wait for the expected writes, then for the halt loop, then compare the log
    task automatic check_results();
        int cycles;
        cycles = 0;
        while (log_addr.size() < exp_addr.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error($sformatf("Timeout: only %0d of %0d expected writes seen",
                                          log_addr.size(), exp_addr.size()));
            end
        end
        cycles = 0;
        while (addr !== halt_addr) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("Timeout: program never reached its final jump loop");
            end
        end
        assert (log_addr.size() == exp_addr.size())
            else report_mismatch($sformatf("%0d writes seen, %0d expected",
                                           log_addr.size(), exp_addr.size()));
        foreach (exp_addr[i]) begin
            assert (log_addr[i] == exp_addr[i] && log_data[i] == exp_data[i])
                else report_mismatch($sformatf("%s: wrote %h to %h, expected %h to %h",
                                               exp_what[i], log_data[i], log_addr[i],
                                               exp_data[i], exp_addr[i]));
        end
    endtask

    `include "cpu_tests.svh"

    initial begin
        reset = 1'b1;                              // Held until the first test
        seed  = 32'hd2d9;
        fill_memory();                             // rdata defined from time zero
        reset_and_jump();
        loads_and_transfers();
        logic_and_add_sub();
        compare_carry();
        decimal_mode();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: hw/alu.sv
// ALU: logic ops, add/subtract with decimal adjust, carry out
`timescale 1ns/100ps

module alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  data_t   a,
    input  data_t   b,
    input  alu_op_t op,
    input  logic    carry_in,
    input  logic    decimal,
    output data_t   result,
    output logic    carry_out
);

    logic       sub;
    data_t      bb;                                // b, inverted for SUB
    logic [4:0] lo_raw, lo, hi_raw, hi;
    logic       half_carry;

    assign sub = (op == ALU_SUB);
    assign bb  = sub ? ~b : b;

    always_comb begin
        lo_raw = {1'b0, a[3:0]} + {1'b0, bb[3:0]} + {4'b0, carry_in};
        if (sub) begin
            half_carry = lo_raw[4];                // Set means no borrow
            lo = (decimal && !half_carry) ? lo_raw - 5'd6 : lo_raw;
        end else begin
            lo = (decimal && lo_raw > 5'd9) ? lo_raw + 5'd6 : lo_raw;
            half_carry = lo[4];                    // Decimal or binary nibble carry
        end
        hi_raw = {1'b0, a[7:4]} + {1'b0, bb[7:4]} + {4'b0, half_carry};
        if (sub) begin
            hi = (decimal && !hi_raw[4]) ? hi_raw - 5'd6 : hi_raw;
            carry_out = hi_raw[4];
        end else begin
            hi = (decimal && hi_raw > 5'd9) ? hi_raw + 5'd6 : hi_raw;
            carry_out = hi[4];
        end
        case (op)
            ALU_OR:  result = a | b;
            ALU_AND: result = a & b;
            ALU_EOR: result = a ^ b;
            ALU_ADD,
            ALU_SUB: result = {hi[3:0], lo[3:0]};
            default: result = a;                   // PASS
        endcase
        if (op != ALU_ADD && op != ALU_SUB) begin
            carry_out = carry_in;                  // Logic ops keep carry
        end
    end

endmodule

// File: hw/core_pkg.sv
// Sequencer states, ALU operations, register selects and control structs
package core_pkg;

    typedef enum logic [3:0] {
        RST0, RST1,                                // Vector low, vector high
        DECODE,                                    // Opcode on the bus
        FETCH,                                     // Operand read, ALU op, abs store
        REG,                                       // Implied, register to register
        ABS0, ABS1,                                // Address low, address high
        JMP0, JMP1                                 // Target low, target high
    } state_t;

    typedef enum logic [2:0] {
        ALU_OR, ALU_AND, ALU_EOR, ALU_ADD, ALU_SUB, ALU_PASS
    } alu_op_t;

    typedef enum logic [1:0] {SEL_A, SEL_X, SEL_Y} reg_sel_t;

    typedef enum logic [1:0] {MODE_IMM, MODE_ABS, MODE_IMPL, MODE_JMP} mode_t;

    typedef enum logic {ASEL_REG, ASEL_ZERO} a_sel_t;
    typedef enum logic {BSEL_MEM, BSEL_ZERO} b_sel_t;
    typedef enum logic [1:0] {CIN_FLAG, CIN_ONE, CIN_ZERO} cin_sel_t;

    // Per-instruction controls, held from one decode to the next
    typedef struct packed {
        alu_op_t  op;
        reg_sel_t src_reg;                         // Operand or store source
        reg_sel_t dst_reg;                         // Written register
        logic     load_reg;
        logic     load_only;                       // LDA/LDX/LDY, A input forced to 0
        logic     store;
        logic     compare;                         // Carry only, no register write
        logic     adc_sbc;                         // Carry update, BCD capable
        logic     inc;                             // INX/INY carry in
        logic     set_c;
        logic     clr_c;
        logic     set_d;
        logic     clr_d;
        mode_t    mode;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{op: ALU_PASS, src_reg: SEL_A, dst_reg: SEL_A,
                                   mode: MODE_IMPL, default: 1'b0};

    // Per-cycle datapath controls from the sequencer
    typedef struct packed {
        alu_op_t  alu_op;
        a_sel_t   alu_a_sel;
        b_sel_t   alu_b_sel;
        cin_sel_t carry_in_sel;
        reg_sel_t reg_sel;                         // Read port, also reg_out
        reg_sel_t dst_sel;                         // Write port
        logic     reg_we;
        logic     flag_we;                         // C from ALU carry
        logic     dec_we;                          // D from selected carry in
        logic     bcd;                             // Decimal adjust allowed
    } dp_ctrl_t;

endpackage

// File: hw/cpu_top.sv
// CPU top: decoder, cycle sequencer and datapath
`timescale 1ns/100ps

module cpu_top
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output addr_t addr,                            // Address bus
    input  data_t rdata,                           // Async read data
    output data_t wdata,                           // Write data
    output logic  we                               // Write on rising edge
);

    logic     decode_stb;                          // One cycle in DECODE
    ctrl_t    ctrl;                                // Latched instruction controls
    dp_ctrl_t dp;                                  // Per-cycle datapath controls
    data_t    reg_out;                             // Selected register

    instr_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .decode_stb (decode_stb),
        .opcode     (rdata),
        .ctrl       (ctrl)
    );

    cycle_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .rdata      (rdata),
        .reg_out    (reg_out),
        .decode_stb (decode_stb),
        .addr       (addr),
        .wdata      (wdata),
        .we         (we),
        .dp         (dp)
    );

    datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .rdata      (rdata),
        .dp         (dp),
        .reg_out    (reg_out),
        .carry_out  ()                             // C is kept inside the datapath
    );

endmodule

// File: hw/cycle_sequencer.sv
// Cycle sequencer: state machine, PC, address bus, write enable, datapath selects
`timescale 1ns/100ps

module cycle_sequencer
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  ctrl_t    ctrl,
    input  data_t    rdata,
    input  data_t    reg_out,
    output logic     decode_stb,
    output addr_t    addr,
    output data_t    wdata,
    output logic     we,
    output dp_ctrl_t dp
);

    state_t state_q;                               // Registered state
    state_t state;                                 // Effective state this cycle
    state_t state_n;
    logic   decoded;                               // First cycle after DECODE
    addr_t  pc;
    addr_t  ea;                                    // Operand address, vector and target low

    // Controls arrive one edge after DECODE, so the mode picks the path here
    always_comb begin
        state = state_q;
        if (decoded) begin
            case (ctrl.mode)
                MODE_IMM:  state = FETCH;
                MODE_ABS:  state = ABS0;
                MODE_IMPL: state = REG;
                default:   state = JMP0;
            endcase
        end
    end

    always_comb begin
        case (state)
            RST0:    state_n = RST1;
            ABS0:    state_n = ABS1;
            ABS1:    state_n = FETCH;              // Data read or store
            JMP0:    state_n = JMP1;
            default: state_n = DECODE;             // RST1, FETCH, REG, JMP1, DECODE
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= RST0;
            decoded <= 1'b0;
            pc      <= '0;
        end else begin
            state_q <= state_n;
            decoded <= (state == DECODE);
            if (state == RST1 || state == JMP1) begin
                pc <= {rdata, ea[7:0]};            // Vector or jump target
            end else if (state == DECODE || state == ABS0 || state == ABS1 ||
                         state == JMP0 || (state == FETCH && ctrl.mode == MODE_IMM)) begin
                pc <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == RST0 || state == ABS0 || state == JMP0) begin
            ea[7:0] <= rdata;                      // Low byte
        end
        if (state == ABS1) begin
            ea[15:8] <= rdata;                     // High byte
        end
    end

    always_comb begin
        case (state)
            RST0:    addr = RESET_VECTOR;
            RST1:    addr = RESET_VECTOR + 16'd1;
            FETCH:   addr = (ctrl.mode == MODE_ABS) ? ea : pc;
            default: addr = pc;
        endcase
    end

    assign decode_stb = (state == DECODE);
    assign we         = (state == FETCH) && ctrl.store;
    assign wdata      = reg_out;                   // Store source selected below

    always_comb begin
        dp = '{alu_op: ALU_PASS, alu_a_sel: ASEL_REG, alu_b_sel: BSEL_ZERO,
               carry_in_sel: CIN_ZERO, reg_sel: ctrl.src_reg, dst_sel: ctrl.dst_reg,
               default: 1'b0};
        if (state == FETCH && !ctrl.store) begin
            dp.alu_op    = ctrl.op;
            dp.alu_a_sel = ctrl.load_only ? ASEL_ZERO : ASEL_REG;
            dp.alu_b_sel = BSEL_MEM;               // Immediate or absolute data
            if (ctrl.compare) begin
                dp.carry_in_sel = CIN_ONE;         // Subtract without borrow
            end else if (ctrl.adc_sbc) begin
                dp.carry_in_sel = CIN_FLAG;
            end
            dp.reg_we  = ctrl.load_reg;
            dp.flag_we = ctrl.adc_sbc || ctrl.compare;
            dp.bcd     = ctrl.adc_sbc;
        end else if (state == REG) begin
            dp.alu_op = ctrl.op;                   // PASS, or ADD/SUB against zero
            if (ctrl.inc || ctrl.set_c || ctrl.set_d) begin
                dp.carry_in_sel = CIN_ONE;
            end
            dp.reg_we  = ctrl.load_reg;
            dp.flag_we = ctrl.set_c || ctrl.clr_c; // PASS hands carry in to C
            dp.dec_we  = ctrl.set_d || ctrl.clr_d;
        end
    end

endmodule

// File: hw/datapath.sv
// Datapath: A, X, Y, carry and decimal flags, ALU
`timescale 1ns/100ps

module datapath
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  data_t    rdata,
    input  dp_ctrl_t dp,
    output data_t    reg_out,
    output logic     carry_out
);

    data_t reg_a, reg_x, reg_y;
    logic  flag_c, flag_d;
    data_t alu_a, alu_b, alu_result;
    logic  alu_cin;

    always_comb begin
        case (dp.reg_sel)
            SEL_X:   reg_out = reg_x;
            SEL_Y:   reg_out = reg_y;
            default: reg_out = reg_a;
        endcase
    end

    assign alu_a = (dp.alu_a_sel == ASEL_ZERO) ? 8'h00 : reg_out;
    assign alu_b = (dp.alu_b_sel == BSEL_ZERO) ? 8'h00 : rdata;

    always_comb begin
        case (dp.carry_in_sel)
            CIN_FLAG: alu_cin = flag_c;
            CIN_ONE:  alu_cin = 1'b1;
            default:  alu_cin = 1'b0;
        endcase
    end

    alu u_alu (
        .a         (alu_a),
        .b         (alu_b),
        .op        (dp.alu_op),
        .carry_in  (alu_cin),
        .decimal   (flag_d && dp.bcd),             // Only ADC/SBC adjust
        .result    (alu_result),
        .carry_out (carry_out)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_a  <= '0;
            reg_x  <= '0;
            reg_y  <= '0;
            flag_c <= 1'b0;
            flag_d <= 1'b0;
        end else begin
            if (dp.reg_we) begin
                case (dp.dst_sel)
                    SEL_X:   reg_x <= alu_result;
                    SEL_Y:   reg_y <= alu_result;
                    default: reg_a <= alu_result;
                endcase
            end
            if (dp.flag_we) flag_c <= carry_out;
            if (dp.dec_we)  flag_d <= alu_cin;     // SED one, CLD zero
        end
    end

endmodule

// File: hw/instr_decoder.sv
// Instruction decoder with registered control word
`timescale 1ns/100ps

module instr_decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  decode_stb,                      // Opcode valid on rdata
    input  data_t opcode,
    output ctrl_t ctrl
);

    ctrl_t dec;                                    // Decode of current opcode

    always_comb begin
        dec = CTRL_NOP;                            // Unknown opcodes run as NOP
        casez (opcode)
            8'b???0_1?01: begin                    // Group one, imm (x9) and abs (xD)
                if (opcode != 8'h89) begin         // No STA immediate
                    dec.mode      = opcode[2] ? MODE_ABS : MODE_IMM;
                    dec.store     = (opcode[7:5] == 3'b100);
                    dec.load_only = (opcode[7:5] == 3'b101);
                    dec.compare   = (opcode[7:5] == 3'b110);
                    dec.adc_sbc   = (opcode[6:5] == 2'b11);    // ADC, SBC
                    dec.load_reg  = !dec.store && !dec.compare;
                    case (opcode[7:5])
                        3'b000:  dec.op = ALU_OR;
                        3'b001:  dec.op = ALU_AND;
                        3'b010:  dec.op = ALU_EOR;
                        3'b011:  dec.op = ALU_ADD;
                        3'b101:  dec.op = ALU_OR;  // 0 | operand
                        default: dec.op = ALU_SUB; // CMP, SBC
                    endcase
                end
            end
            OPC_LDX_IMM, OPC_LDX_ABS,
            OPC_LDY_IMM, OPC_LDY_ABS: begin
                dec.mode      = opcode[3] ? MODE_ABS : MODE_IMM;
                dec.op        = ALU_OR;
                dec.load_reg  = 1'b1;
                dec.load_only = 1'b1;
                dec.dst_reg   = opcode[1] ? SEL_X : SEL_Y;
                dec.src_reg   = dec.dst_reg;
            end
            OPC_STX_ABS, OPC_STY_ABS: begin
                dec.mode    = MODE_ABS;
                dec.store   = 1'b1;
                dec.src_reg = opcode[1] ? SEL_X : SEL_Y;
            end
            OPC_JMP_ABS: dec.mode = MODE_JMP;
            OPC_TAX, OPC_TAY: begin
                dec.load_reg = 1'b1;
                dec.dst_reg  = (opcode == OPC_TAX) ? SEL_X : SEL_Y;
            end
            OPC_TXA, OPC_TYA: begin
                dec.load_reg = 1'b1;
                dec.src_reg  = (opcode == OPC_TXA) ? SEL_X : SEL_Y;
            end
            OPC_INX, OPC_INY, OPC_DEX, OPC_DEY: begin
                dec.load_reg = 1'b1;
                dec.inc      = (opcode == OPC_INX) || (opcode == OPC_INY);
                dec.op       = dec.inc ? ALU_ADD : ALU_SUB;  // r + 0 + 1 or r + FF
                dec.src_reg  = (opcode == OPC_INX) || (opcode == OPC_DEX) ? SEL_X : SEL_Y;
                dec.dst_reg  = dec.src_reg;
            end
            OPC_CLC: dec.clr_c = 1'b1;
            OPC_SEC: dec.set_c = 1'b1;
            OPC_CLD: dec.clr_d = 1'b1;
            OPC_SED: dec.set_d = 1'b1;
            default: dec = CTRL_NOP;               // NOP and all others
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl <= CTRL_NOP;
        end else if (decode_stb) begin
            ctrl <= dec;                           // Held until next strobe
        end
    end

endmodule

// File: hw/isa_pkg.sv
// Architectural types, reset vector and opcode values
package isa_pkg;

    typedef logic [7:0]  data_t;                   // Data bus byte
    typedef logic [15:0] addr_t;                   // Address bus

    localparam addr_t RESET_VECTOR = 16'hfffc;     // Low vector byte, high at +1

    localparam data_t OPC_JMP_ABS = 8'h4c;
    localparam data_t OPC_LDA_IMM = 8'ha9;
    localparam data_t OPC_LDA_ABS = 8'had;
    localparam data_t OPC_LDX_IMM = 8'ha2;
    localparam data_t OPC_LDX_ABS = 8'hae;
    localparam data_t OPC_LDY_IMM = 8'ha0;
    localparam data_t OPC_LDY_ABS = 8'hac;
    localparam data_t OPC_STA_ABS = 8'h8d;
    localparam data_t OPC_STX_ABS = 8'h8e;
    localparam data_t OPC_STY_ABS = 8'h8c;
    localparam data_t OPC_ORA_IMM = 8'h09;
    localparam data_t OPC_AND_IMM = 8'h29;
    localparam data_t OPC_EOR_IMM = 8'h49;
    localparam data_t OPC_ADC_IMM = 8'h69;
    localparam data_t OPC_CMP_IMM = 8'hc9;
    localparam data_t OPC_SBC_IMM = 8'he9;
    localparam data_t OPC_TAX     = 8'haa;
    localparam data_t OPC_TXA     = 8'h8a;
    localparam data_t OPC_TAY     = 8'ha8;
    localparam data_t OPC_TYA     = 8'h98;
    localparam data_t OPC_INX     = 8'he8;
    localparam data_t OPC_INY     = 8'hc8;
    localparam data_t OPC_DEX     = 8'hca;
    localparam data_t OPC_DEY     = 8'h88;
    localparam data_t OPC_CLC     = 8'h18;
    localparam data_t OPC_SEC     = 8'h38;
    localparam data_t OPC_CLD     = 8'hd8;
    localparam data_t OPC_SED     = 8'hf8;
    localparam data_t OPC_NOP     = 8'hea;

endpackage

// File: list.f
+incdir+include
hw/isa_pkg.sv
hw/core_pkg.sv
hw/alu.sv
hw/datapath.sv
hw/instr_decoder.sv
hw/cycle_sequencer.sv
hw/cpu_top.sv
dv/cpu_tb.sv
